// File: cp0Top.f
rtl/cp0MapPkg.sv
rtl/cp0FieldPkg.sv
rtl/cp0WriteDecode.sv
rtl/cp0Timer.sv
rtl/cp0ExceptionRegs.sv
rtl/cp0ReadPort.sv
rtl/cp0Top.sv
tb/cp0Tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cp0Tb -f cp0Top.f -o cp0Sim \
    && ./obj_dir/cp0Sim > sim.log 2>&1
cat sim.log 2>/dev/null
[ -s sim.log ] && ! grep -q "Test FAILED" sim.log \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"

// File: tb/cp0Tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Tb
    import cp0MapPkg::*;
    import cp0FieldPkg::*;
();

    localparam int          COUNT_DIV  = 2;
    localparam logic [31:0] PRID_VALUE = 32'h0001_8000;
    localparam int          MAX_CYCLES = 3000; // whole sequence takes about 400 cycles

    logic        clk;
    logic        rst;
    mtc0Req      wrReq;
    cp0Addr      rdAddr;
    excEvent     exc;
    logic        eret;
    logic [5:0]  hwInt;
    logic [31:0] rdData;
    logic [31:0] epcOut;
    logic [31:0] statusOut;
    logic [31:0] causeOut;
    logic        intReq;
    logic        kernelMode;

    integer      seed;
    int          cycleCount = 0;

    // expected register contents
    logic [31:0] expStatus;
    logic [31:0] expCauseSw;  // software ip bits 9:8
    logic [31:0] expCauseExc; // bd and exception code
    logic [31:0] expEpc;
    logic [31:0] expBad;
    logic [31:0] expCompare;
    logic [31:0] expConfig;
    logic        expTimer;

    cp0Top #(
        .COUNT_DIV  (COUNT_DIV),
        .PRID_VALUE (PRID_VALUE)
    ) cp0Top_inst (
        .clk        (clk),
        .rst        (rst),
        .wrReq      (wrReq),
        .rdAddr     (rdAddr),
        .exc        (exc),
        .eret       (eret),
        .hwInt      (hwInt),
        .rdData     (rdData),
        .epcOut     (epcOut),
        .statusOut  (statusOut),
        .causeOut   (causeOut),
        .intReq     (intReq),
        .kernelMode (kernelMode)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1);
    endtask

    // ip[6:2] follow hwInt[4:0] one clock late, ip7 is the timer
    function automatic logic [31:0] causeModel();
        logic [31:0] w;
        w        = expCauseExc | expCauseSw;
        w[14:10] = hwInt[4:0];
        w[15]    = expTimer;
        return w;
    endfunction

    function automatic logic [31:0] excBits(input logic bd, input excCodeT code);
        logic [31:0] w;
        w      = '0;
        w[31]  = bd;
        w[6:2] = code;
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expVal);
        assert (got === expVal) else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expVal);
            abortRun();
        end
    endtask

    task automatic readReg(input cp0Addr addr, output logic [31:0] value);
        rdAddr = addr;
        #1;
        value = rdData;
    endtask

    task automatic checkReg(input string name, input cp0Addr addr, input logic [31:0] expVal);
        logic [31:0] got;
        readReg(addr, got);
        checkValue(name, got, expVal);
    endtask

    task automatic checkModel();
        checkReg("Status", REG_STATUS, expStatus);
        checkReg("Cause", REG_CAUSE, causeModel());
        checkReg("EPC", REG_EPC, expEpc);
        checkReg("BadVAddr", REG_BADVADDR, expBad);
        checkReg("Compare", REG_COMPARE, expCompare);
        checkReg("Config", REG_CONFIG, expConfig);
        checkReg("PRId", REG_PRID, PRID_VALUE);
        checkValue("statusOut", statusOut, expStatus);
        checkValue("causeOut", causeOut, causeModel());
        checkValue("epcOut", epcOut, expEpc);
        checkValue("kernelMode", {31'd0, kernelMode}, {31'd0, expStatus[1]});
    endtask

    // one cycle of strobes, driven just after the edge and released after the next one
    task automatic pulseEvent(input excEvent ev, input logic eretIn, input mtc0Req req);
        @(posedge clk);
        #1;
        exc   = ev;
        eret  = eretIn;
        wrReq = req;
        @(posedge clk);
        #1;
        exc   = '0;
        eret  = 1'b0;
        wrReq = '0;
    endtask

    task automatic writeReg(input cp0Addr addr, input logic [31:0] data);
        mtc0Req req;
        req.valid = 1'b1;
        req.addr  = addr;
        req.data  = data;
        pulseEvent('0, 1'b0, req);
    endtask

    task automatic verifyResetState();
        checkReg("Count", REG_COUNT, 32'd0);
        checkReg("Random", REG_RANDOM, 32'd0);
        checkModel();
        checkValue("intReq", {31'd0, intReq}, 32'd0);
        for (int a = 0; a < 32; a++) begin
            if (!(a inside {1, 8, 9, 11, 12, 13, 14, 15, 16})) begin
                checkReg($sformatf("reg %0d", a), 5'(a), 32'd0);
            end
        end
    endtask

    task automatic exerciseWrites();
        logic [31:0] d;
        for (int i = 0; i < 8; i++) begin
            d = $random(seed);
            writeReg(REG_STATUS, d);
            expStatus = (d & STATUS_WMASK) | (expStatus & ~STATUS_WMASK);
            checkModel();
            d = $random(seed);
            writeReg(REG_CAUSE, d);
            expCauseSw = d & CAUSE_WMASK;
            checkModel();
            d = $random(seed);
            writeReg(REG_EPC, d);
            expEpc = d;
            d = $random(seed);
            writeReg(REG_BADVADDR, d);
            expBad = d;
            d = $random(seed) | 32'h8000_0000; // far above count, no timer match
            writeReg(REG_COMPARE, d);
            expCompare = d;
            d = $random(seed);
            writeReg(REG_CONFIG, d);
            expConfig = (d & CONFIG_WMASK) | 32'h0000_8000;
            checkModel();
        end
        writeReg(REG_PRID, $random(seed));
        checkModel();
    endtask

    task automatic measureCountRate();
        logic [31:0] c0;
        logic [31:0] c1;
        for (int n = 6; n <= 18; n += 6) begin
            @(posedge clk);
            #1;
            readReg(REG_COUNT, c0);
            repeat (n) @(posedge clk);
            #1;
            readReg(REG_COUNT, c1);
            checkValue("Count delta", c1 - c0, 32'(n / COUNT_DIV));
        end
        readReg(REG_COUNT, c0);
        readReg(REG_RANDOM, c1);
        assert (c1 === c0 || c1 === c0 - 32'd1) else begin
            $display("[FAIL] Random: 0x%08h does not trail Count 0x%08h", c1, c0);
            abortRun();
        end
    endtask

    task automatic runTimerInterrupt();
        logic [31:0] c;
        logic [31:0] v;
        int          waited;
        readReg(REG_COUNT, c);
        writeReg(REG_COMPARE, c + 32'd20);
        expCompare = c + 32'd20;
        waited     = 0;
        v          = '0;
        while (!v[15] && waited < 45) begin
            @(posedge clk);
            #1;
            waited++;
            readReg(REG_CAUSE, v);
        end
        assert (v[15]) else begin
            $display("timer interrupt did not show in Cause IP7 within 45 cycles");
            abortRun();
        end
        expTimer = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #1;
            checkModel();
        end
        // timerInt drops at the write edge, Cause IP7 one clock later
        writeReg(REG_COMPARE, 32'd0);
        expCompare = 32'd0;
        checkModel();
        @(posedge clk);
        #1;
        expTimer = 1'b0;
        checkModel();
    endtask

    task automatic enterAndReturn();
        excEvent ev;
        mtc0Req  req;
        writeReg(REG_STATUS, 32'h0000_ff01); // user mode, interrupts on
        expStatus = (32'h0000_ff01 & STATUS_WMASK) | (expStatus & ~STATUS_WMASK);
        checkModel();
        ev.valid    = 1'b1;
        ev.code     = ADEL;
        ev.bd       = 1'b1;
        ev.epc      = $random(seed);
        ev.badVAddr = $random(seed);
        ev.badValid = 1'b1;
        req.valid   = 1'b1;
        req.addr    = REG_EPC;
        req.data    = $random(seed);
        pulseEvent(ev, 1'b0, req); // the mtc0 to EPC loses
        expEpc       = ev.epc;
        expBad       = ev.badVAddr;
        expCauseExc  = excBits(1'b1, ADEL);
        expStatus[1] = 1'b1;
        checkModel();
        ev.code     = SYS;
        ev.bd       = 1'b0;
        ev.epc      = $random(seed);
        ev.badVAddr = $random(seed);
        ev.badValid = 1'b0;
        req.addr    = REG_BADVADDR;
        pulseEvent(ev, 1'b1, req); // exception also beats eret
        expEpc      = ev.epc;
        expCauseExc = excBits(1'b0, SYS);
        checkModel();
        req.addr = REG_STATUS;
        req.data = 32'd0;
        pulseEvent('0, 1'b1, req); // eret beats the status write
        expStatus[1] = 1'b0;
        checkModel();
    endtask

    task automatic sweepInterruptRequest();
        logic [31:0] d;
        logic [31:0] st;
        logic [31:0] ca;
        logic        expReq;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #1;
            hwInt = 6'($random(seed));
            d     = $random(seed);
            if (i % 2 == 0) begin
                d[1:0] = 2'b01;
            end
            writeReg(REG_STATUS, d);
            expStatus = (d & STATUS_WMASK) | (expStatus & ~STATUS_WMASK);
            d = $random(seed);
            writeReg(REG_CAUSE, d);
            expCauseSw = d & CAUSE_WMASK;
            checkModel();
            readReg(REG_STATUS, st);
            readReg(REG_CAUSE, ca);
            expReq = st[0] & ~st[1] & (|(ca[15:8] & st[15:8]));
            checkValue("intReq", {31'd0, intReq}, {31'd0, expReq});
        end
    endtask

    initial begin
        seed        = 32'h33ee_9d42;
        rst         = 1'b1;
        wrReq       = '0;
        rdAddr      = '0;
        exc         = '0;
        eret        = 1'b0;
        hwInt       = '0;
        expStatus   = STATUS_RESET;
        expCauseSw  = '0;
        expCauseExc = '0;
        expEpc      = '0;
        expBad      = '0;
        expCompare  = '0;
        expConfig   = 32'h0000_8000;
        expTimer    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        verifyResetState();
        exerciseWrites();
        measureCountRate();
        runTimerInterrupt();
        enterAndReturn();
        sweepInterruptRequest();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/cp0Top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Top
    import cp0MapPkg::*;
    import cp0FieldPkg::*;
#(
    parameter int          COUNT_DIV  = 2,
    parameter logic [31:0] PRID_VALUE = 32'h0001_8000
) (
    input  logic        clk,
    input  logic        rst,
    input  mtc0Req      wrReq,
    input  cp0Addr      rdAddr,
    input  excEvent     exc,
    input  logic        eret,
    input  logic [5:0]  hwInt,
    output logic [31:0] rdData,
    output logic [31:0] epcOut,
    output logic [31:0] statusOut,
    output logic [31:0] causeOut,
    output logic        intReq,
    output logic        kernelMode
);

    cp0WrSel     wrSel;
    statusWord   status;
    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] random;
    logic        timerInt;

    assign statusOut = status.raw;

    cp0WriteDecode decodeInst (
        .wrReq (wrReq),
        .exc   (exc),
        .eret  (eret),
        .wrSel (wrSel)
    );

    cp0Timer #(
        .COUNT_DIV (COUNT_DIV)
    ) timerInst (
        .clk      (clk),
        .rst      (rst),
        .wrSel    (wrSel),
        .count    (count),
        .compare  (compare),
        .random   (random),
        .timerInt (timerInt)
    );

    cp0ExceptionRegs excRegsInst (
        .clk        (clk),
        .rst        (rst),
        .wrSel      (wrSel),
        .hwInt      (hwInt),
        .timerInt   (timerInt),
        .status     (status),
        .cause      (causeOut),
        .epc        (epcOut),
        .badVAddr   (badVAddr),
        .intReq     (intReq),
        .kernelMode (kernelMode)
    );

    cp0ReadPort #(
        .PRID_VALUE (PRID_VALUE)
    ) readPortInst (
        .clk      (clk),
        .rst      (rst),
        .wrSel    (wrSel),
        .rdAddr   (rdAddr),
        .status   (status),
        .cause    (causeOut),
        .epc      (epcOut),
        .badVAddr (badVAddr),
        .count    (count),
        .compare  (compare),
        .random   (random),
        .rdData   (rdData)
    );

endmodule

`default_nettype wire

// File: rtl/cp0ReadPort.sv
`timescale 1ns/1ps
`default_nettype none

module cp0ReadPort
    import cp0MapPkg::*;
    import cp0FieldPkg::*;
#(
    parameter logic [31:0] PRID_VALUE = 32'h0001_8000
) (
    input  logic        clk,
    input  logic        rst,
    input  cp0WrSel     wrSel,
    input  cp0Addr      rdAddr,
    input  statusWord   status,
    input  logic [31:0] cause,
    input  logic [31:0] epc,
    input  logic [31:0] badVAddr,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic [31:0] random,
    output logic [31:0] rdData
);

    logic [31:0] configReg;
    logic [31:0] prid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            configReg <= ~CONFIG_WMASK; // only the fixed bit is set
        end else if (wrSel.cfg) begin
            configReg <= (wrSel.data & CONFIG_WMASK) | ~CONFIG_WMASK;
        end
    end

    // processor id is loaded at reset and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prid <= PRID_VALUE;
        end
    end

    always_comb begin
        case (rdAddr)
            REG_RANDOM:   rdData = random;
            REG_BADVADDR: rdData = badVAddr;
            REG_COUNT:    rdData = count;
            REG_COMPARE:  rdData = compare;
            REG_STATUS:   rdData = status.raw;
            REG_CAUSE:    rdData = cause;
            REG_EPC:      rdData = epc;
            REG_PRID:     rdData = prid;
            REG_CONFIG:   rdData = configReg;
            default:      rdData = 32'd0; // tlb, watch, debug and cache regs not built
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cp0ExceptionRegs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0ExceptionRegs
    import cp0MapPkg::*;
    import cp0FieldPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cp0WrSel     wrSel,
    input  logic [5:0]  hwInt,
    input  logic        timerInt,
    output statusWord   status,
    output logic [31:0] cause,
    output logic [31:0] epc,
    output logic [31:0] badVAddr,
    output logic        intReq,
    output logic        kernelMode
);

    causeFields causeQ;
    logic [7:0] pending;

    // status: exl is set on entry, cleared on eret
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status.raw <= STATUS_RESET;
        end else if (wrSel.excEntry) begin
            status.f.exl <= 1'b1;
        end else if (wrSel.eret) begin
            status.f.exl <= 1'b0;
        end else if (wrSel.status) begin
            status.raw <= wrSel.data; // decoder already fixed the read-only bits
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            causeQ <= '0;
        end else begin
            // hw line 5 shares ip7 with the timer, timer wins
            causeQ.ip[7:2] <= {timerInt, hwInt[4:0]};
            if (wrSel.excEntry) begin
                causeQ.excCode <= wrSel.exc.code;
                causeQ.bd      <= wrSel.exc.bd;
            end
            if (wrSel.causeSw) begin
                causeQ.ip[1:0] <= wrSel.data[9:8]; // software interrupt bits
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epc <= '0;
        end else if (wrSel.excEntry) begin
            epc <= wrSel.exc.epc;
        end else if (wrSel.epc) begin
            epc <= wrSel.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddr <= '0;
        end else if (wrSel.excEntry) begin
            if (wrSel.exc.badValid) begin
                badVAddr <= wrSel.exc.badVAddr; // only address errors carry a bad address
            end
        end else if (wrSel.badVAddr) begin
            badVAddr <= wrSel.data;
        end
    end

    assign cause   = causeQ;
    assign pending = causeQ.ip & status.f.im;

    assign intReq     = status.f.ie & ~status.f.exl & (|pending);
    assign kernelMode = status.f.exl;

endmodule

`default_nettype wire

// File: rtl/cp0Timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Timer
    import cp0FieldPkg::*;
#(
    parameter int COUNT_DIV = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  cp0WrSel     wrSel,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic [31:0] random,
    output logic        timerInt
);

    localparam int PRE_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [PRE_W-1:0] preCnt;
    logic             tick;

    assign tick = (preCnt == PRE_W'(COUNT_DIV - 1)); // last clock of the prescale period

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            preCnt <= '0;
            count  <= '0;
        end else if (tick) begin
            preCnt <= '0;
            count  <= count + 32'd1;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            random <= '0;
        end else begin
            random <= count; // trails count by one clock
        end
    end

    // a compare write acknowledges the timer interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            compare  <= '0;
            timerInt <= 1'b0;
        end else if (wrSel.compare) begin
            compare  <= wrSel.data;
            timerInt <= 1'b0;
        end else if (compare != 32'd0 && count == compare) begin
            timerInt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cp0WriteDecode.sv
`timescale 1ns/1ps
`default_nettype none

module cp0WriteDecode
    import cp0MapPkg::*;
    import cp0FieldPkg::*;
(
    input  mtc0Req  wrReq,
    input  excEvent exc,
    input  logic    eret,
    output cp0WrSel wrSel
);

    logic mtc0Ok;

    // exception beats eret, eret beats mtc0
    assign mtc0Ok = wrReq.valid & ~exc.valid & ~eret;

    always_comb begin
        wrSel          = '0;
        wrSel.exc      = exc;
        wrSel.excEntry = exc.valid;
        wrSel.eret     = eret & ~exc.valid;
        wrSel.data     = wrReq.data;

        if (mtc0Ok) begin
            case (wrReq.addr)
                REG_STATUS: begin
                    wrSel.status = 1'b1;
                    // read-only status bits keep their fixed values
                    wrSel.data   = (wrReq.data & STATUS_WMASK) |
                                   (STATUS_RESET & ~STATUS_WMASK);
                end
                REG_CAUSE: begin
                    wrSel.causeSw = 1'b1;
                    wrSel.data    = wrReq.data & CAUSE_WMASK;
                end
                REG_EPC: begin
                    wrSel.epc = 1'b1;
                end
                REG_BADVADDR: begin
                    wrSel.badVAddr = 1'b1;
                end
                REG_COMPARE: begin
                    wrSel.compare = 1'b1;
                end
                REG_CONFIG: begin
                    wrSel.cfg = 1'b1;
                end
                default: begin
                    // prid, count, random and unused numbers ignore writes
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cp0FieldPkg.sv
`default_nettype none

package cp0FieldPkg;

    import cp0MapPkg::*;

    typedef enum logic [4:0] {
        INT  = 5'd0,  // interrupt
        ADEL = 5'd4,  // address error on load or fetch
        ADES = 5'd5,  // address error on store
        SYS  = 5'd8,  // syscall
        BP   = 5'd9,  // breakpoint
        RI   = 5'd10, // reserved instruction
        OV   = 5'd12  // arithmetic overflow
    } excCodeT;

    typedef struct packed {
        logic [8:0] zeroHi;  // 31:23
        logic       bev;     // 22
        logic [5:0] zeroMid; // 21:16
        logic [7:0] im;      // interrupt mask
        logic [5:0] zeroLo;  // 7:2
        logic       exl;     // exception level, kernel mode when set
        logic       ie;      // global interrupt enable
    } statusFields;

    typedef union packed {
        logic [31:0] raw;
        statusFields f;
    } statusWord;

    typedef struct packed {
        logic        bd;      // exception taken in a branch delay slot
        logic [14:0] zeroHi;  // 30:16
        logic [7:0]  ip;      // pending interrupts, [1:0] are software bits
        logic        zero7;
        excCodeT     excCode;
        logic [1:0]  zeroLo;
    } causeFields;

    typedef struct packed {
        logic        valid;
        cp0Addr      addr;
        logic [31:0] data;
    } mtc0Req;

    typedef struct packed {
        logic        valid;
        excCodeT     code;
        logic        bd;
        logic [31:0] epc;
        logic [31:0] badVAddr;
        logic        badValid; // badVAddr carries a faulting address
    } excEvent;

    // one-hot register selections after priority, at most one strobe set
    typedef struct packed {
        logic        status;
        logic        causeSw;
        logic        epc;
        logic        badVAddr;
        logic        compare;
        logic        cfg;    // config register
        logic        excEntry;
        logic        eret;
        logic [31:0] data;   // mtc0 data, already masked where needed
        excEvent     exc;    // event payload for exception entry
    } cp0WrSel;

endpackage

`default_nettype wire

// File: rtl/cp0MapPkg.sv
`default_nettype none

package cp0MapPkg;

    typedef logic [4:0] cp0Addr; // cp0 register number

    // implemented register numbers
    localparam cp0Addr REG_RANDOM   = 5'd1;
    localparam cp0Addr REG_BADVADDR = 5'd8;
    localparam cp0Addr REG_COUNT    = 5'd9;
    localparam cp0Addr REG_COMPARE  = 5'd11;
    localparam cp0Addr REG_STATUS   = 5'd12;
    localparam cp0Addr REG_CAUSE    = 5'd13;
    localparam cp0Addr REG_EPC      = 5'd14;
    localparam cp0Addr REG_PRID     = 5'd15;
    localparam cp0Addr REG_CONFIG   = 5'd16;

    // software-writable bits of each register
    localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03; // im, exl, ie
    localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300; // software ip bits only
    localparam logic [31:0] CONFIG_WMASK = 32'hffff_7fff; // bit 15 is tied high

    // bev set, all interrupts masked in, kernel mode, interrupts off
    localparam logic [31:0] STATUS_RESET = 32'h0040_ff02;

endpackage

`default_nettype wire
